// File: rtl/rf_macros.svh
`ifndef RF_MACROS_SVH
`define RF_MACROS_SVH

// ******************************
// Register file sizing
// ******************************
`define REG_WIDTH 5
`define ROB_WIDTH 4
`define N_REGS (1 << `REG_WIDTH)

// ******************************
// Accumulators
// ******************************
`define N_CORE 4
`define N_ACC 3
`define ACC_BASE (`N_REGS - `N_ACC) // First accumulator register.
`define ADD_LATENCY 6

`define REG_SP_INIT 32'h0000_fff0 // Top of the stack.

`endif

// File: rtl/core_pkg.sv
`default_nettype none
`include "rf_macros.svh"

package core_pkg;

	typedef logic [`REG_WIDTH-1:0] reg_num_t;
	typedef logic [`ROB_WIDTH-1:0] rob_tag_t;

	// One architectural register, also the read payload.
	typedef struct packed {
		logic valid;
		rob_tag_t tag; // Pending producer.
		logic [31:0] data;
	} reg_entry_t;

	typedef struct packed {
		reg_num_t rd;
		reg_num_t rs1;
		reg_num_t rs2;
	} inst_regs_t;

	typedef struct packed {
		logic valid;
		reg_num_t arch_num;
		rob_tag_t tag;
		logic [31:0] data;
	} commit_t;

endpackage

`default_nettype wire

// File: rtl/acc_pkg.sv
`default_nettype none

package acc_pkg;

	// One core's operand for one accumulator.
	typedef struct packed {
		logic valid;
		logic [31:0] operand;
	} acc_req_t;

	// Writeback into the accumulator register.
	typedef struct packed {
		logic valid;
		logic [31:0] sum;
	} acc_result_t;

endpackage

`default_nettype wire

// File: rtl/add_pipe.sv
`default_nettype none
`include "rf_macros.svh"

module add_pipe #(
	parameter int STAGES = `ADD_LATENCY
) (
	input logic clk,
	input logic [31:0] a,
	input logic [31:0] b,
	output logic [31:0] sum
);

	logic [31:0] stage [STAGES];

	always_ff @(posedge clk) begin
		stage[0] <= a + b; // Stands in for the FP adder.
	end

	for (genvar s = 1; s < STAGES; s++) begin : g_stage
		always_ff @(posedge clk) begin
			stage[s] <= stage[s-1];
		end
	end

	assign sum = stage[STAGES-1];

endmodule

`default_nettype wire

// File: rtl/acc_unit.sv
`default_nettype none
`include "rf_macros.svh"

module acc_unit
	import acc_pkg::*;
(
	input logic clk,
	input logic reset,
	input acc_req_t req [`N_CORE],
	output logic [`N_CORE-1:0] ready,
	input logic [31:0] acc_value,
	output acc_result_t result,
	output logic idle
);

	localparam int CNT_W = $clog2(`ADD_LATENCY + 1);

	logic [CNT_W-1:0] count;
	logic [`N_CORE-1:0] grant;
	logic dispatch;
	logic [31:0] operand;
	logic [31:0] op_a;
	logic [31:0] sum;

	assign idle = count <= CNT_W'(1); // Free again in the writeback cycle.

	// ******************************
	// Fixed-priority arbitration
	// ******************************
	always_comb begin
		logic blocked;
		blocked = 1'b0;
		operand = '0;
		for (int k = 0; k < `N_CORE; k++) begin
			ready[k] = idle && !blocked;
			grant[k] = ready[k] && req[k].valid;
			if (grant[k]) begin
				operand = req[k].operand;
			end
			blocked = blocked || req[k].valid; // Lower index wins.
		end
	end

	assign dispatch = |grant;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (dispatch) begin
			count <= CNT_W'(`ADD_LATENCY);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// ******************************
	// Adder and bypass
	// ******************************
	assign op_a = result.valid ? sum : acc_value; // Register is stale this cycle.

	add_pipe #(
		.STAGES(`ADD_LATENCY)
	) u_add (
		.clk(clk),
		.a(op_a),
		.b(operand),
		.sum(sum)
	);

	assign result.valid = count == CNT_W'(1);
	assign result.sum = sum;

	a_one_grant: assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant));

	// Next dispatch no earlier than the writeback cycle.
	a_no_overlap: assert property (@(posedge clk) disable iff (reset)
		dispatch |=> !dispatch [*`ADD_LATENCY-1]);

endmodule

`default_nettype wire

// File: rtl/arch_regfile.sv
`default_nettype none
`include "rf_macros.svh"

module arch_regfile
	import core_pkg::*;
	import acc_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic issue,
	input rob_tag_t issue_tag,
	input inst_regs_t inst,
	input commit_t commit,
	input acc_result_t acc_result [`N_ACC],
	output reg_entry_t read_port [2],
	output logic [`N_ACC-1:0][31:0] acc_value
);

	reg_entry_t regs [`N_REGS];

	// ******************************
	// Register entries
	// ******************************
	for (genvar i = 0; i < `N_REGS; i++) begin : g_reg
		localparam logic [31:0] INIT_DATA = (i == 1) ? `REG_SP_INIT : 32'd0;

		reg_entry_t entry;
		logic acc_wr;
		logic [31:0] acc_sum;
		logic is_rd;
		logic is_named;

		if (i >= `ACC_BASE) begin : g_acc
			assign acc_wr = acc_result[i - `ACC_BASE].valid;
			assign acc_sum = acc_result[i - `ACC_BASE].sum;
		end else begin : g_plain
			assign acc_wr = 1'b0;
			assign acc_sum = 32'd0;
		end

		assign is_rd = issue && inst.rd == reg_num_t'(i);
		assign is_named = commit.arch_num == reg_num_t'(i);

		always_ff @(posedge clk) begin
			if (reset) begin
				entry.valid <= 1'b1;
				entry.tag <= '0;
				entry.data <= INIT_DATA;
			end else begin
				if (is_rd) begin
					entry.valid <= 1'b0; // Issue beats commit.
					entry.tag <= issue_tag;
				end else if (commit.valid && entry.tag == commit.tag) begin
					entry.valid <= 1'b1; // Every sharer of the tag.
				end

				if (acc_wr) begin
					entry.data <= acc_sum;
				end else if (commit.valid && !entry.valid && is_named) begin
					entry.data <= commit.data;
				end
			end
		end

		assign regs[i] = entry;
	end

	assign read_port[0] = regs[inst.rs1];
	assign read_port[1] = regs[inst.rs2];

	for (genvar j = 0; j < `N_ACC; j++) begin : g_acc_out
		assign acc_value[j] = regs[`ACC_BASE + j].data;

		// Renaming must keep accumulators out of flight.
		a_no_issue_on_wb: assert property (@(posedge clk) disable iff (reset)
			!(acc_result[j].valid && issue && inst.rd == reg_num_t'(`ACC_BASE + j)));
	end

	// A waiting register only takes data from its own producer.
	a_commit_owner: assert property (@(posedge clk) disable iff (reset)
		commit.valid && !regs[commit.arch_num].valid
			|-> regs[commit.arch_num].tag == commit.tag);

endmodule

`default_nettype wire

// File: rtl/rf_top.sv
`default_nettype none
`include "rf_macros.svh"

module rf_top
	import core_pkg::*;
	import acc_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic issue,
	input rob_tag_t issue_tag,
	input inst_regs_t inst,
	input commit_t commit,
	input acc_req_t acc_req [`N_CORE][`N_ACC],
	output logic acc_ready [`N_CORE][`N_ACC],
	output reg_entry_t read_port [2],
	output logic acc_idle,
	output logic no_acc_req
);

	acc_result_t acc_result [`N_ACC];
	logic [`N_ACC-1:0][31:0] acc_value;
	logic [`N_ACC-1:0] unit_idle;
	acc_req_t unit_req [`N_ACC][`N_CORE];
	logic [`N_CORE-1:0] unit_ready [`N_ACC];
	logic [`N_CORE*`N_ACC-1:0] req_valid;

	arch_regfile u_regfile (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.issue_tag(issue_tag),
		.inst(inst),
		.commit(commit),
		.acc_result(acc_result),
		.read_port(read_port),
		.acc_value(acc_value)
	);

	// ******************************
	// One unit per accumulator
	// ******************************
	for (genvar j = 0; j < `N_ACC; j++) begin : g_acc
		for (genvar k = 0; k < `N_CORE; k++) begin : g_core
			assign unit_req[j][k] = acc_req[k][j]; // Regroup by accumulator.
			assign acc_ready[k][j] = unit_ready[j][k];
			assign req_valid[k*`N_ACC + j] = acc_req[k][j].valid;
		end

		acc_unit u_acc (
			.clk(clk),
			.reset(reset),
			.req(unit_req[j]),
			.ready(unit_ready[j]),
			.acc_value(acc_value[j]),
			.result(acc_result[j]),
			.idle(unit_idle[j])
		);
	end

	assign acc_idle = &unit_idle;
	assign no_acc_req = ~|req_valid;

endmodule

`default_nettype wire

// File: sim/rf_checker.sv
`default_nettype none
`include "rf_macros.svh"

module rf_checker
	import core_pkg::*;
(
	input logic clk,
	input logic enable,
	input reg_entry_t read_port [2],
	input reg_entry_t exp_read [2],
	input logic acc_ready [`N_CORE][`N_ACC],
	input logic exp_ready [`N_CORE][`N_ACC],
	input logic acc_idle,
	input logic exp_idle,
	input logic no_acc_req,
	input logic exp_no_req,
	output int read_errors,
	output int ctrl_errors
);

	int read_count = 0;
	int ctrl_count = 0;

	assign read_errors = read_count;
	assign ctrl_errors = ctrl_count;

	// Inputs settle at the falling edge, so the rising edge sees stable values.
	always @(posedge clk) begin
		if (enable) begin
			for (int p = 0; p < 2; p++) begin
				if (read_port[p] !== exp_read[p]) begin
					$display("Mismatch read_port%0d exp=%h got=%h", p, exp_read[p], read_port[p]);
					read_count++;
				end
			end
			for (int k = 0; k < `N_CORE; k++) begin
				for (int j = 0; j < `N_ACC; j++) begin
					if (acc_ready[k][j] !== exp_ready[k][j]) begin
						$display("Mismatch acc_ready[%0d][%0d] exp=%h got=%h",
							k, j, exp_ready[k][j], acc_ready[k][j]);
						ctrl_count++;
					end
				end
			end
			if (acc_idle !== exp_idle) begin
				$display("Mismatch acc_idle exp=%h got=%h", exp_idle, acc_idle);
				ctrl_count++;
			end
			if (no_acc_req !== exp_no_req) begin
				$display("Mismatch no_acc_req exp=%h got=%h", exp_no_req, no_acc_req);
				ctrl_count++;
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/tb_rf.sv
`default_nettype none
`include "rf_macros.svh"

module tb_rf
	import core_pkg::*;
	import acc_pkg::*;
();

	localparam int RESET_CYCLES = 3;
	localparam int DIRECTED_CYCLES = 80;
	localparam int RAND_CYCLES = 300;
	localparam int CYCLE_LIMIT = RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES
		+ 20 * `ADD_LATENCY;

	logic clk;
	logic reset;
	logic issue;
	rob_tag_t issue_tag;
	inst_regs_t inst;
	commit_t commit;
	acc_req_t acc_req [`N_CORE][`N_ACC];
	logic acc_ready [`N_CORE][`N_ACC];
	reg_entry_t read_port [2];
	logic acc_idle;
	logic no_acc_req;

	logic check_en;
	reg_entry_t exp_read [2];
	logic exp_ready [`N_CORE][`N_ACC];
	logic exp_idle;
	logic exp_no_req;
	int read_errors;
	int ctrl_errors;

	// ******************************
	// Shadow model
	// ******************************
	reg_entry_t model [`N_REGS];
	int busy [`N_ACC];
	logic [31:0] pend [`N_ACC]; // Sum on its way to the accumulator.
	logic req_v [`N_CORE][`N_ACC]; // Held until accepted.
	logic [31:0] req_op [`N_CORE][`N_ACC];
	logic [31:0] rng = 32'ha0f3;
	int cycles = 0;

	rf_top u_dut (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.issue_tag(issue_tag),
		.inst(inst),
		.commit(commit),
		.acc_req(acc_req),
		.acc_ready(acc_ready),
		.read_port(read_port),
		.acc_idle(acc_idle),
		.no_acc_req(no_acc_req)
	);

	rf_checker u_chk (
		.clk(clk),
		.enable(check_en),
		.read_port(read_port),
		.exp_read(exp_read),
		.acc_ready(acc_ready),
		.exp_ready(exp_ready),
		.acc_idle(acc_idle),
		.exp_idle(exp_idle),
		.no_acc_req(no_acc_req),
		.exp_no_req(exp_no_req),
		.read_errors(read_errors),
		.ctrl_errors(ctrl_errors)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic reg_entry_t expected_entry(input reg_num_t r);
		return model[r];
	endfunction

	function automatic logic accumulators_active();
		logic active;
		active = 1'b0;
		for (int j = 0; j < `N_ACC; j++) begin
			active = active || busy[j] != 0;
			for (int k = 0; k < `N_CORE; k++) begin
				active = active || req_v[k][j];
			end
		end
		return active;
	endfunction

	// Advances the model by the rising edge just passed, from the inputs it saw.
	task automatic apply_edge();
		reg_entry_t old [`N_REGS];
		logic res_v [`N_ACC];
		logic [31:0] res_s [`N_ACC];
		logic [31:0] base;
		logic taken;
		old = model;
		for (int j = 0; j < `N_ACC; j++) begin
			res_v[j] = busy[j] == 1;
			res_s[j] = pend[j];
			base = res_v[j] ? pend[j] : old[`ACC_BASE + j].data; // Bypass.
			taken = 1'b0;
			for (int k = 0; k < `N_CORE; k++) begin
				if (!taken && busy[j] <= 1 && acc_req[k][j].valid) begin
					pend[j] = base + acc_req[k][j].operand;
					req_v[k][j] = 1'b0;
				end
				taken = taken || acc_req[k][j].valid; // Lowest index wins.
			end
			if (taken && busy[j] <= 1) begin
				busy[j] = `ADD_LATENCY;
			end else if (busy[j] != 0) begin
				busy[j]--;
			end
		end
		for (int i = 0; i < `N_REGS; i++) begin
			if (issue && inst.rd == reg_num_t'(i)) begin
				model[i].valid = 1'b0;
				model[i].tag = issue_tag;
			end else if (commit.valid && old[i].tag == commit.tag) begin
				model[i].valid = 1'b1;
			end
			if (commit.valid && !old[i].valid && commit.arch_num == reg_num_t'(i)) begin
				model[i].data = commit.data;
			end
		end
		for (int j = 0; j < `N_ACC; j++) begin
			if (res_v[j]) begin
				model[`ACC_BASE + j].data = res_s[j]; // Beats the commit.
			end
		end
	endtask

	task automatic drive_and_expect();
		logic blocked;
		exp_idle = 1'b1;
		exp_no_req = 1'b1;
		for (int j = 0; j < `N_ACC; j++) begin
			blocked = 1'b0;
			for (int k = 0; k < `N_CORE; k++) begin
				acc_req[k][j].valid = req_v[k][j];
				acc_req[k][j].operand = req_op[k][j];
				exp_ready[k][j] = busy[j] <= 1 && !blocked;
				blocked = blocked || req_v[k][j];
			end
			exp_idle = exp_idle && busy[j] <= 1;
			exp_no_req = exp_no_req && !blocked;
		end
		exp_read[0] = expected_entry(inst.rs1);
		exp_read[1] = expected_entry(inst.rs2);
		check_en = 1'b1;
	endtask

	task automatic run_cycle();
		drive_and_expect();
		@(negedge clk);
		apply_edge();
		issue = 1'b0;
		commit.valid = 1'b0;
	endtask

	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the tests did not finish", cycles);
		$display("Errors: %0d on read ports, %0d on handshake and status",
			read_errors, ctrl_errors);
		$display("Test failed");
		$finish;
	end

	initial begin
		logic [31:0] r;
		reset = 1'b1;
		issue = 1'b0;
		issue_tag = '0;
		inst = '0;
		commit = '0;
		check_en = 1'b0;
		for (int k = 0; k < `N_CORE; k++) begin
			for (int j = 0; j < `N_ACC; j++) begin
				acc_req[k][j] = '0;
				req_v[k][j] = 1'b0;
				req_op[k][j] = '0;
			end
		end
		for (int j = 0; j < `N_ACC; j++) begin
			busy[j] = 0;
			pend[j] = '0;
		end
		for (int i = 0; i < `N_REGS; i++) begin
			model[i].valid = 1'b1;
			model[i].tag = '0;
			model[i].data = (i == 1) ? `REG_SP_INIT : 32'd0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// ******************************
		// Directed tests
		// ******************************
		for (int i = 0; i < `N_REGS; i += 2) begin
			inst.rs1 = reg_num_t'(i);
			inst.rs2 = reg_num_t'(i + 1);
			run_cycle();
		end

		inst.rs1 = reg_num_t'(5);
		inst.rs2 = reg_num_t'(6);
		issue = 1'b1;
		inst.rd = reg_num_t'(5);
		issue_tag = rob_tag_t'(3);
		run_cycle();
		commit = '{valid: 1'b1, arch_num: reg_num_t'(5), tag: rob_tag_t'(3),
			data: 32'hcafe_0005};
		run_cycle();
		commit = '{valid: 1'b1, arch_num: reg_num_t'(6), tag: model[6].tag,
			data: 32'hdead_beef}; // Already valid.
		run_cycle();
		run_cycle();

		inst.rs1 = reg_num_t'(7);
		inst.rs2 = reg_num_t'(8);
		issue = 1'b1;
		inst.rd = reg_num_t'(7);
		issue_tag = rob_tag_t'(9);
		run_cycle();
		issue = 1'b1;
		inst.rd = reg_num_t'(8);
		run_cycle();
		commit = '{valid: 1'b1, arch_num: reg_num_t'(8), tag: rob_tag_t'(9),
			data: 32'h1234_5678};
		run_cycle();
		run_cycle();

		inst.rs1 = reg_num_t'(`ACC_BASE);
		inst.rs2 = reg_num_t'(`ACC_BASE + 1);
		for (int k = 1; k < `N_CORE; k++) begin
			req_v[k][0] = 1'b1;
			req_op[k][0] = 32'h100 * k + 1;
		end
		req_v[0][1] = 1'b1;
		req_op[0][1] = 32'h0000_0042;
		req_v[2][2] = 1'b1;
		req_op[2][2] = 32'hffff_fff0;
		while (accumulators_active()) begin
			run_cycle();
		end

		inst.rs1 = reg_num_t'(`ACC_BASE + 1);
		issue = 1'b1;
		inst.rd = reg_num_t'(`ACC_BASE + 1);
		issue_tag = rob_tag_t'(5);
		run_cycle();
		req_v[0][1] = 1'b1;
		req_op[0][1] = 32'h0000_1000;
		run_cycle();
		while (busy[1] != 1) begin
			run_cycle();
		end
		commit = '{valid: 1'b1, arch_num: reg_num_t'(`ACC_BASE + 1), tag: rob_tag_t'(5),
			data: 32'hbad0_bad0}; // Lands with the sum.
		run_cycle();
		run_cycle();

		// ******************************
		// Random traffic
		// ******************************
		for (int n = 0; n < RAND_CYCLES; n++) begin
			r = next_rand();
			issue = r[0];
			issue_tag = r[4:1];
			inst.rd = reg_num_t'(r[9:5] % `ACC_BASE); // Accumulators stay unrenamed.
			inst.rs1 = r[14:10];
			inst.rs2 = r[19:15];
			commit.valid = r[20];
			commit.arch_num = r[25:21];
			commit.tag = model[r[25:21]].tag;
			commit.data = next_rand();
			for (int k = 0; k < `N_CORE; k++) begin
				for (int j = 0; j < `N_ACC; j++) begin
					if (!req_v[k][j] && next_rand() < 32'h4000_0000) begin
						req_v[k][j] = 1'b1;
						req_op[k][j] = next_rand();
					end
				end
			end
			run_cycle();
		end
		while (accumulators_active()) begin
			run_cycle();
		end
		run_cycle();

		$display("Errors: %0d on read ports, %0d on handshake and status",
			read_errors, ctrl_errors);
		if (read_errors + ctrl_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+rtl
rtl/core_pkg.sv
rtl/acc_pkg.sv
rtl/add_pipe.sv
rtl/acc_unit.sv
rtl/arch_regfile.sv
rtl/rf_top.sv
sim/rf_checker.sv
sim/tb_rf.sv

// File: Bender.yml
package:
  name: rf_accum

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/core_pkg.sv
      - rtl/acc_pkg.sv
      - rtl/add_pipe.sv
      - rtl/acc_unit.sv
      - rtl/arch_regfile.sv
      - rtl/rf_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - sim/rf_checker.sv
      - sim/tb_rf.sv
